// File: fpm.f
src/fpm_pkg.sv
src/booth_encoder.sv
src/csa_tree.sv
src/normalize_round.sv
src/exp_adjust.sv
src/result_select.sv
src/fpm_top.sv
+incdir+sim
sim/fpm_tb.sv

// File: sim/fpm_model.svh
`ifndef FPM_MODEL_SVH
`define FPM_MODEL_SVH

logic [31:0] lfsr_state;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

task automatic model_mul(input fp32_u a, input fp32_u b, input logic [2:0] rm,
                         output fp32_u z, output logic ov, output logic ud);
  logic [47:0] p;
  logic [47:0] sh;
  logic [23:0] kept;
  logic        g;
  logic        rb;
  logic        st;
  logic        up;
  logic [24:0] sig_r;
  logic [22:0] fr;
  logic        nrm;
  logic        sgn;
  logic        a_max;
  logic        b_max;
  logic        a_zero;
  logic        b_zero;
  int          e_sum;
  int          e_bias;
  sgn = a.f.sign ^ b.f.sign;
  p = 48'({1'b1, a.f.frac}) * 48'({1'b1, b.f.frac});
  sh = p[47] ? p : (p << 1);
  kept = sh[47:24];
  g = sh[23];
  rb = sh[22];
  st = |sh[21:0];
  case (rm)
    RM_RNE:  up = g & (rb | st | kept[0]);
    RM_RTZ:  up = 1'b0;
    RM_RDN:  up = sgn;
    RM_RUP:  up = ~sgn;
    default: up = g;
  endcase
  sig_r = {1'b0, kept} + 25'(up);
  fr = sig_r[24] ? sig_r[23:1] : sig_r[22:0];
  nrm = p[47] | sig_r[24];
  e_sum = int'(a.f.exp) + int'(b.f.exp);
  e_bias = 127 - int'(nrm);
  ud = (e_sum <= e_bias);
  ov = (e_sum >= 255 + e_bias);
  a_max = (a.f.exp == 8'hff);
  b_max = (b.f.exp == 8'hff);
  a_zero = (a.f.exp == 8'h00);
  b_zero = (b.f.exp == 8'h00);
  z.raw = {sgn, 8'(e_sum - e_bias), fr};
  if ((a_max && a.f.frac != 0) || (b_max && b.f.frac != 0) ||
      (a_max && b_zero) || (b_max && a_zero)) begin
    z.raw = QNAN_WORD;
  end else if (a_max || b_max || ov) begin
    z.raw = {sgn, 8'hff, 23'd0};
  end else if (a_zero || b_zero || ud) begin
    z.raw = {sgn, 31'd0};
  end
endtask

`endif

// File: sim/fpm_tb.sv
`timescale 1ns/1ps

module fpm_tb import fpm_pkg::*; ();

  localparam int N_RST = 3;
  localparam int N_RAND = 512;
  localparam int N_RND = 256;
  localparam int N_SPC = 64;
  localparam int N_OVF = 120;
  localparam int N_B2B = 256;
  localparam int TOTAL_OPS = N_RST + N_RAND + N_RND + N_SPC + N_OVF + N_B2B;
  localparam int TIMEOUT_NS = TOTAL_OPS * 10 * 2 + 1000;

  logic       clk;
  logic       rst;
  logic [2:0] r_mode;
  fp32_u      fp_x;
  fp32_u      fp_y;
  fp32_u      fp_z;
  logic       ovrf;
  logic       udrf;

  int    err_cnt;
  int    pass_cnt;
  int    fail_cnt;
  fp32_u last_z; // result of the op before the current one

  `include "fpm_model.svh"

  fpm_top dut0 (
    .clk    (clk),
    .rst    (rst),
    .r_mode (r_mode),
    .fp_x   (fp_x),
    .fp_y   (fp_y),
    .fp_z   (fp_z),
    .ovrf   (ovrf),
    .udrf   (udrf)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run timed out after %0d ns", TIMEOUT_NS);
    $display("tests failed");
    $finish;
  end

  task automatic compare_word(input string name, input fp32_u want, input fp32_u got);
    if (got !== want) begin
      $display("mismatch %s: expected %h actual %h", name, want.raw, got.raw);
      err_cnt++;
    end
  endtask

  task automatic compare_flag(input string name, input logic want, input logic got);
    if (got !== want) begin
      $display("mismatch %s: expected %b actual %b", name, want, got);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == 0) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt);
    end
    err_cnt = 0;
  endtask

  // normal operand with exponent in 64..190
  function automatic fp32_u rand_normal();
    fp32_u w;
    w.f.sign = 1'(rand_bits(1));
    w.f.exp  = 8'(64 + rand_bits(7) % 127);
    w.f.frac = 23'(rand_bits(23));
    return w;
  endfunction

  // 0 zero, 1 inf, 2 nan, else normal
  function automatic fp32_u special_operand(input int cls);
    fp32_u w;
    w = rand_normal();
    case (cls)
      0: w.f.exp = '0; // fraction ignored
      1: begin
        w.f.exp  = '1;
        w.f.frac = '0;
      end
      2: begin
        w.f.exp     = '1;
        w.f.frac[0] = 1'b1;
      end
      default: ;
    endcase
    return w;
  endfunction

  // called on a falling edge, returns on the next one
  task automatic run_op(input string name, input fp32_u x, input fp32_u y,
                        input logic [2:0] rm, input logic hold);
    fp32_u want_z;
    logic  want_o;
    logic  want_u;
    model_mul(x, y, rm, want_z, want_o, want_u);
    fp_x   = x;
    fp_y   = y;
    r_mode = rm;
    if (hold) begin
      #1;
      compare_word({name, " hold"}, last_z, fp_z);
    end
    @(negedge clk);
    compare_word(name, want_z, fp_z);
    compare_flag({name, " ovrf"}, want_o, ovrf);
    compare_flag({name, " udrf"}, want_u, udrf);
    last_z = want_z;
  endtask

  initial begin
    fp32_u x;
    fp32_u y;
    int    zb;
    int    t;
    lfsr_state = 32'hcf3f;
    err_cnt  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    last_z   = '0;
    rst      = 1'b1;
    r_mode   = RM_RUP;
    fp_x     = rand_normal();
    fp_y     = rand_normal();
    fp_x.f.exp = 8'd200; // sum 400 raises ovrf
    fp_y.f.exp = 8'd200;

    for (int i = 0; i < N_RST; i++) begin
      @(negedge clk);
      compare_word("reset fp_z", '0, fp_z);
      compare_flag("reset ovrf", 1'b0, ovrf);
      compare_flag("reset udrf", 1'b0, udrf);
      // alternate underflow and overflow operands
      fp_x.f.exp = (i % 2 == 0) ? 8'd1 : 8'd200;
      fp_y.f.exp = (i % 2 == 0) ? 8'd1 : 8'd200;
    end
    rst = 1'b0;
    end_test("reset");

    for (int i = 0; i < N_RAND; i++) begin
      x = rand_normal();
      y = rand_normal();
      run_op("random normal", x, y, 3'(i % 8), 1'b0);
    end
    end_test("random normal");

    for (int i = 0; i < N_RND; i++) begin
      x = rand_normal();
      y = rand_normal();
      if (rand_bits(2) == 0) begin
        x.f.frac = '1; // directed modes round into a carry-out
        y.f.frac = '0;
      end else begin
        zb = 10 + int'(rand_bits(3));
        x.f.frac = x.f.frac & ~((23'd1 << zb) - 23'd1);
        y.f.frac = y.f.frac & ~((23'd1 << zb) - 23'd1);
      end
      run_op("rounding corner", x, y, 3'(i % 8), 1'b0);
    end
    end_test("rounding corner");

    // every class pair four times
    for (int ca = 0; ca < 4; ca++) begin
      for (int cb = 0; cb < 4; cb++) begin
        for (int k = 0; k < N_SPC / 16; k++) begin
          x = special_operand(ca);
          y = special_operand(cb);
          run_op("special operand", x, y, 3'(rand_bits(3)), 1'b0);
        end
      end
    end
    end_test("special operand");

    for (int i = 0; i < N_OVF; i++) begin
      x = rand_normal();
      y = rand_normal();
      if (i % 2 == 0) begin
        t = 125 + (i / 2) % 5; // around the underflow edge
        x.f.exp = 8'(1 + rand_bits(6));
      end else begin
        t = 380 + (i / 2) % 5;
        x.f.exp = 8'(190 + rand_bits(6));
      end
      y.f.exp = 8'(t - int'(x.f.exp));
      run_op("overflow underflow", x, y, 3'(rand_bits(3)), 1'b0);
    end
    end_test("overflow underflow");

    for (int i = 0; i < N_B2B; i++) begin
      x.raw = rand_bits(32);
      y.raw = rand_bits(32);
      run_op("back to back", x, y, 3'(rand_bits(3)), 1'b1);
    end
    end_test("back to back");

    $display("summary: %0d passed, %0d failing", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: src/fpm_top.sv
`timescale 1ns/1ps

module fpm_top import fpm_pkg::*; #(
  parameter int FRAC_W   = fpm_pkg::FRAC_W,
  parameter int EXP_W    = fpm_pkg::EXP_W,
  parameter int SIG_W    = fpm_pkg::SIG_W,
  parameter int PROD_W   = fpm_pkg::PROD_W,
  parameter int PP_ROWS  = fpm_pkg::PP_ROWS,
  parameter int EXP_BIAS = fpm_pkg::EXP_BIAS
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] r_mode,
  input  fp32_u      fp_x,
  input  fp32_u      fp_y,
  output fp32_u      fp_z,
  output logic       ovrf,
  output logic       udrf
);

  logic              sign_z;
  logic [SIG_W-1:0]  sig_x;
  logic [SIG_W-1:0]  sig_y;
  logic [PROD_W-1:0] pp [0:PP_ROWS];
  logic [PROD_W-1:0] product;
  logic [FRAC_W-1:0] frac_z;
  logic              norm;
  logic [EXP_W-1:0]  exp_z;
  logic              ovrf_c;
  logic              udrf_c;

  assign sign_z = fp_x.f.sign ^ fp_y.f.sign;
  assign sig_x  = {1'b1, fp_x.f.frac}; // hidden one
  assign sig_y  = {1'b1, fp_y.f.frac};

  booth_encoder #(.SIG_W(SIG_W), .PROD_W(PROD_W), .PP_ROWS(PP_ROWS)) booth0 (
    .x  (sig_x),
    .y  (sig_y),
    .pp (pp)
  );

  csa_tree #(.ROWS(PP_ROWS + 1), .WIDTH(PROD_W)) tree0 (
    .rows    (pp),
    .product (product)
  );

  normalize_round #(.SIG_W(SIG_W), .PROD_W(PROD_W)) round0 (
    .product (product),
    .sign    (sign_z),
    .r_mode  (r_mode),
    .frac    (frac_z),
    .norm    (norm)
  );

  exp_adjust #(.EXP_W(EXP_W), .EXP_BIAS(EXP_BIAS)) exp0 (
    .exp_x (fp_x.f.exp),
    .exp_y (fp_y.f.exp),
    .norm  (norm),
    .exp_z (exp_z),
    .ovrf  (ovrf_c),
    .udrf  (udrf_c)
  );

  // only clocked stage of the multiplier
  result_select sel0 (
    .clk     (clk),
    .rst     (rst),
    .a       (fp_x),
    .b       (fp_y),
    .sign    (sign_z),
    .exp_z   (exp_z),
    .frac_z  (frac_z),
    .ovrf_in (ovrf_c),
    .udrf_in (udrf_c),
    .fp_z    (fp_z),
    .ovrf    (ovrf),
    .udrf    (udrf)
  );

endmodule

// File: src/result_select.sv
`timescale 1ns/1ps

module result_select import fpm_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  fp32_u             a,
  input  fp32_u             b,
  input  logic              sign,
  input  logic [EXP_W-1:0]  exp_z,
  input  logic [FRAC_W-1:0] frac_z,
  input  logic              ovrf_in,
  input  logic              udrf_in,
  output fp32_u             fp_z,
  output logic              ovrf,
  output logic              udrf
);

  logic  a_max;
  logic  b_max;
  logic  a_zero;
  logic  b_zero;
  logic  nan;
  logic  inf;
  logic  zero;
  fp32_u res;

  assign a_max  = &a.f.exp;
  assign b_max  = &b.f.exp;
  assign a_zero = ~|a.f.exp; // no denormals, exp 0 is zero
  assign b_zero = ~|b.f.exp;

  // inf times zero lands here too
  assign nan  = (a_max & |a.f.frac) | (b_max & |b.f.frac) |
                (a_max & b_zero) | (b_max & a_zero);
  assign inf  = (a_max & ~|a.f.frac) | (b_max & ~|b.f.frac) | ovrf_in;
  assign zero = a_zero | b_zero | udrf_in;

  always_comb begin
    res.f.sign = sign;
    res.f.exp  = exp_z;
    res.f.frac = frac_z;
    if (nan) begin
      res.raw = QNAN_WORD;
    end else if (inf) begin
      res.f.exp  = '1;
      res.f.frac = '0;
    end else if (zero) begin
      res.f.exp  = '0;
      res.f.frac = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fp_z <= '0;
      ovrf <= 1'b0;
      udrf <= 1'b0;
    end else begin
      fp_z <= res;
      ovrf <= ovrf_in;
      udrf <= udrf_in;
    end
  end

endmodule

// File: src/exp_adjust.sv
`timescale 1ns/1ps

module exp_adjust import fpm_pkg::*; #(
  parameter int EXP_W    = fpm_pkg::EXP_W,
  parameter int EXP_BIAS = fpm_pkg::EXP_BIAS
) (
  input  logic [EXP_W-1:0] exp_x,
  input  logic [EXP_W-1:0] exp_y,
  input  logic             norm,
  output logic [EXP_W-1:0] exp_z,
  output logic             ovrf,
  output logic             udrf
);

  localparam int EXP_MAX = 2 ** EXP_W - 1;

  logic [EXP_W:0] exp_sum;
  logic [EXP_W:0] bias_eff;

  assign exp_sum = {1'b0, exp_x} + {1'b0, exp_y};

  // a normalize shift bumps the exponent, so take one off the bias
  assign bias_eff = (EXP_W + 1)'(EXP_BIAS) - {{EXP_W{1'b0}}, norm};

  assign udrf = exp_sum <= bias_eff;
  assign ovrf = {1'b0, exp_sum} >= (EXP_W + 2)'(EXP_MAX) + {1'b0, bias_eff};

  assign exp_z = EXP_W'(exp_sum - bias_eff); // wraps when a flag is set

endmodule

// File: src/normalize_round.sv
`timescale 1ns/1ps

module normalize_round import fpm_pkg::*; #(
  parameter int SIG_W  = fpm_pkg::SIG_W,
  parameter int PROD_W = fpm_pkg::PROD_W
) (
  input  logic [PROD_W-1:0] product,
  input  logic              sign,
  input  logic [2:0]        r_mode,
  output logic [SIG_W-2:0]  frac,
  output logic              norm
);

  logic [PROD_W-1:0] shifted;
  logic [SIG_W-1:0]  kept;
  logic              guard;
  logic              rnd;
  logic              sticky;
  logic              inc;
  logic [SIG_W:0]    rounded;

  // product of two 1.x values is in [1,4), so one shift at most
  assign shifted = product[PROD_W-1] ? product : product << 1;

  assign kept   = shifted[PROD_W-1 -: SIG_W];
  assign guard  = shifted[PROD_W-SIG_W-1];
  assign rnd    = shifted[PROD_W-SIG_W-2];
  assign sticky = |shifted[PROD_W-SIG_W-3:0];

  always_comb begin
    case (r_mode)
      RM_RNE:  inc = guard & (rnd | sticky | kept[0]);
      RM_RTZ:  inc = 1'b0;
      RM_RDN:  inc = sign;  // magnitude grows for negatives
      RM_RUP:  inc = ~sign;
      default: inc = guard; // RMM and the spare codes
    endcase
  end

  assign rounded = {1'b0, kept} + (SIG_W + 1)'(inc);

  // carry out means all ones rolled over, renormalize
  assign frac = rounded[SIG_W] ? rounded[SIG_W-1:1] : rounded[SIG_W-2:0];
  assign norm = product[PROD_W-1] | rounded[SIG_W];

endmodule

// File: src/csa_tree.sv
`timescale 1ns/1ps

module csa_tree import fpm_pkg::*; #(
  parameter int ROWS  = PP_ROWS + 1,
  parameter int WIDTH = PROD_W
) (
  input  logic [WIDTH-1:0] rows [ROWS],
  output logic [WIDTH-1:0] product
);

  // each group of three becomes sum + carry and leftovers pass
  function automatic int next_rows(input int n);
    return 2 * (n / 3) + n % 3;
  endfunction

  function automatic int rows_at(input int lvl);
    int n;
    n = ROWS;
    for (int k = 0; k < lvl; k++) begin
      n = next_rows(n);
    end
    return n;
  endfunction

  function automatic int num_levels();
    int n;
    int lvl;
    n   = ROWS;
    lvl = 0;
    while (n > 2) begin
      n   = next_rows(n);
      lvl = lvl + 1;
    end
    return lvl;
  endfunction

  localparam int LEVELS = num_levels(); // 14 rows take 6 levels

  for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
    localparam int N = rows_at(l);

    logic [WIDTH-1:0] r [N];

    if (l == 0) begin : g_in
      for (genvar k = 0; k < N; k++) begin : g_cp
        assign r[k] = rows[k];
      end
    end else begin : g_csa
      localparam int P = rows_at(l - 1);
      localparam int G = P / 3;

      for (genvar g = 0; g < G; g++) begin : g_fa
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] c;

        assign a = g_lvl[l-1].r[3*g];
        assign b = g_lvl[l-1].r[3*g+1];
        assign c = g_lvl[l-1].r[3*g+2];

        assign r[2*g]   = a ^ b ^ c;
        assign r[2*g+1] = ((a & b) | (a & c) | (b & c)) << 1; // carry out of top drops
      end

      for (genvar k = 3 * G; k < P; k++) begin : g_pass
        assign r[2*G+k-3*G] = g_lvl[l-1].r[k];
      end
    end
  end

  // single carry-propagate add at the end
  assign product = g_lvl[LEVELS].r[0] + g_lvl[LEVELS].r[1];

endmodule

// File: src/booth_encoder.sv
`timescale 1ns/1ps

module booth_encoder import fpm_pkg::*; #(
  parameter int SIG_W   = fpm_pkg::SIG_W,
  parameter int PROD_W  = fpm_pkg::PROD_W,
  parameter int PP_ROWS = fpm_pkg::PP_ROWS
) (
  input  logic [SIG_W-1:0]  x,
  input  logic [SIG_W-1:0]  y,
  output logic [PROD_W-1:0] pp [0:PP_ROWS]
);

  // multiplier with a zero below bit 0 and zeros above the msb
  logic [2*PP_ROWS:0] x_ext;
  logic [PP_ROWS-1:0] neg;
  logic [PROD_W-1:0]  neg_row;

  assign x_ext = {{(2 * PP_ROWS - SIG_W){1'b0}}, x, 1'b0};

  for (genvar i = 0; i < PP_ROWS; i++) begin : g_row
    logic [2:0]        trip;
    logic              sgl;
    logic              dbl;
    logic [PROD_W-1:0] mag;

    assign trip = x_ext[2*i+2 -: 3];

    // booth digit decode
    assign sgl    = trip[0] ^ trip[1];
    assign dbl    = (trip[2] & ~trip[1] & ~trip[0]) | (~trip[2] & trip[1] & trip[0]);
    assign neg[i] = trip[2];

    assign mag = ({PROD_W{sgl}} & PROD_W'(y)) |
                 ({PROD_W{dbl}} & (PROD_W'(y) << 1));

    // the +1 of the two's complement goes to neg_row
    assign pp[i] = (neg[i] ? ~mag : mag) << (2 * i);
  end

  // negate bits sit at the lsb of their row
  always_comb begin
    neg_row = '0;
    for (int i = 0; i < PP_ROWS; i++) begin
      neg_row[2*i] = neg[i];
    end
  end

  assign pp[PP_ROWS] = neg_row;

endmodule

// File: src/fpm_pkg.sv
package fpm_pkg;

  // binary32 field widths
  localparam int FRAC_W = 23;
  localparam int EXP_W  = 8;
  localparam int SIG_W  = FRAC_W + 1; // hidden one on top
  localparam int PROD_W = 2 * SIG_W;

  // radix-4 digits for an unsigned SIG_W-bit multiplier
  localparam int PP_ROWS = SIG_W / 2 + 1;

  localparam int EXP_BIAS = 127;

  localparam logic [31:0] QNAN_WORD = 32'h7fc0_0000;

  // codes 5..7 fall back to RMM
  localparam logic [2:0] RM_RNE = 3'd0; // nearest, ties to even
  localparam logic [2:0] RM_RTZ = 3'd1;
  localparam logic [2:0] RM_RDN = 3'd2; // toward -inf
  localparam logic [2:0] RM_RUP = 3'd3; // toward +inf
  localparam logic [2:0] RM_RMM = 3'd4; // nearest, ties away

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp32_s;

  // same word seen as raw bits or as fields
  typedef union packed {
    logic [31:0] raw;
    fp32_s       f;
  } fp32_u;

endpackage
